// File: logic/icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// cache geometry
`define ICACHE_WAYS 4
`define ICACHE_SETS 64
`define ICACHE_SET_BITS 6
`define ICACHE_TAG_BITS 22
`define ICACHE_LINE_BITS 128
`define ICACHE_OFFSET_BITS 4

// datapath widths
`define ICACHE_INST_BITS 32
`define ICACHE_ADDR_BITS 32

// captured fetch address after reset
`define ICACHE_RESET_PC 32'h0000_0000

`endif

// File: logic/icachePkg.sv
`default_nettype none

`include "icache_macros.svh"

package icachePkg;

    typedef logic [`ICACHE_ADDR_BITS-1:0] addrT;
    typedef logic [`ICACHE_TAG_BITS-1:0] tagT;
    typedef logic [`ICACHE_SET_BITS-1:0] setT;
    typedef logic [`ICACHE_LINE_BITS-1:0] lineT;
    typedef logic [`ICACHE_INST_BITS-1:0] instT;
    typedef logic [`ICACHE_WAYS-1:0] wayMaskT;
    // bit 2 picks the pair, bit 1 covers ways 2/3, bit 0 ways 0/1
    typedef logic [2:0] plruT;

    typedef enum logic [1:0] {
        run,
        refill,
        recover,
        idleReset
    } ctrlStateT;

endpackage

`default_nettype wire

// File: logic/cacheWay.sv
`default_nettype none

`include "icache_macros.svh"

module cacheWay (
    input  wire                  clk,
    input  wire                  rst,
    input  wire icachePkg::setT  rdSet,
    input  wire icachePkg::tagT  lookupTag,
    input  wire                  wrEn,
    input  wire icachePkg::setT  wrSet,
    input  wire icachePkg::tagT  wrTag,
    input  wire icachePkg::lineT wrLine,
    output logic                 hit,
    output logic                 lineValid,
    output icachePkg::lineT      rdLine
);

    icachePkg::tagT          tagMem  [`ICACHE_SETS];
    icachePkg::lineT         dataMem [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0] validBits;
    icachePkg::setT          rdSetQ;

    // registered read index, arrays are read through it
    always_ff @(posedge clk) begin
        if (rst) begin
            rdSetQ <= '0;
        end else begin
            rdSetQ <= rdSet;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
        end else if (wrEn) begin
            validBits[wrSet] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            tagMem[wrSet]  <= wrTag;
            dataMem[wrSet] <= wrLine;
        end
    end

    assign lineValid = validBits[rdSetQ];
    assign hit       = lineValid && (tagMem[rdSetQ] == lookupTag);
    assign rdLine    = dataMem[rdSetQ];

endmodule

`default_nettype wire

// File: logic/waySelect.sv
`default_nettype none

`include "icache_macros.svh"

module waySelect (
    input  wire                     clk,
    input  wire                     rst,
    input  wire icachePkg::setT     set,
    input  wire icachePkg::wayMaskT wayHit,
    input  wire icachePkg::wayMaskT wayValid,
    input  wire                     fillEn,
    output logic                    hit,
    output icachePkg::wayMaskT      hitWay,
    output icachePkg::wayMaskT      wayFill
);

    icachePkg::plruT    plru [`ICACHE_SETS];
    icachePkg::plruT    cur;
    icachePkg::wayMaskT victim;
    icachePkg::wayMaskT useWay;

    assign hit = |wayHit;
    assign cur = plru[set];

    // lowest hitting way wins
    always_comb begin
        hitWay = '0;
        for (int i = `ICACHE_WAYS - 1; i >= 0; i--) begin
            if (wayHit[i]) begin
                hitWay    = '0;
                hitWay[i] = 1'b1;
            end
        end
    end

    // an empty way first, otherwise walk the tree away from recent use
    always_comb begin
        victim = '0;
        if (&wayValid) begin
            if (cur[2]) begin
                victim = cur[1] ? 4'b1000 : 4'b0100;
            end else begin
                victim = cur[0] ? 4'b0010 : 4'b0001;
            end
        end else begin
            for (int i = `ICACHE_WAYS - 1; i >= 0; i--) begin
                if (!wayValid[i]) begin
                    victim    = '0;
                    victim[i] = 1'b1;
                end
            end
        end
    end

    assign wayFill = fillEn ? victim : '0;
    assign useWay  = fillEn ? victim : hitWay;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ICACHE_SETS; i++) begin
                plru[i] <= '0;
            end
        end else if (useWay[0] || useWay[1]) begin
            plru[set][2] <= 1'b1;
            plru[set][0] <= useWay[0];
        end else if (useWay[2] || useWay[3]) begin
            plru[set][2] <= 1'b0;
            plru[set][1] <= useWay[2];
        end
    end

endmodule

`default_nettype wire

// File: logic/fetchCtrl.sv
`default_nettype none

`include "icache_macros.svh"

module fetchCtrl (
    input  wire                  clk,
    input  wire                  rst,
    input  wire icachePkg::addrT pc,
    input  wire                  flush,
    input  wire                  hit,
    input  wire                  memReqReady,
    input  wire                  memRespValid,
    output logic                 pauseReq,
    output logic                 memReqValid,
    output icachePkg::addrT      memReqAddr,
    output icachePkg::setT       rdSet,
    output icachePkg::tagT       lookupTag,
    output icachePkg::addrT      fetchAddr,
    output logic                 fillEn,
    output icachePkg::setT       fillSet,
    output logic                 outValid,
    output logic                 fromResp
);

    icachePkg::ctrlStateT state;
    icachePkg::ctrlStateT nextState;
    logic                 outstanding;
    logic                 outstandingNext;
    logic                 accept;

    // a miss in run keeps requesting until memory takes it
    assign memReqValid = (state == icachePkg::run) && !hit;

    // only one line request can be in flight
    assign outstandingNext = (outstanding && !memRespValid) || (memReqValid && memReqReady);

    always_comb begin
        nextState = state;
        accept    = 1'b0;
        fillEn    = 1'b0;
        outValid  = 1'b0;
        fromResp  = 1'b0;
        case (state)
            icachePkg::idleReset: begin
                accept    = 1'b1;
                nextState = icachePkg::run;
            end
            icachePkg::run: begin
                if (hit) begin
                    accept   = 1'b1;
                    outValid = 1'b1;
                end else if (memReqReady) begin
                    nextState = icachePkg::refill;
                end
            end
            icachePkg::refill: begin
                if (memRespValid) begin
                    accept    = 1'b1;
                    fillEn    = 1'b1;
                    outValid  = 1'b1;
                    fromResp  = 1'b1;
                    nextState = icachePkg::run;
                end
            end
            icachePkg::recover: begin
                // the late line is dropped, not written
                if (memRespValid) begin
                    accept    = 1'b1;
                    nextState = icachePkg::run;
                end
            end
            default: begin
                nextState = icachePkg::idleReset;
            end
        endcase
        // flush aborts the miss, but a request in flight must still be waited out
        if (flush) begin
            fillEn    = 1'b0;
            outValid  = 1'b0;
            accept    = !outstandingNext;
            nextState = outstandingNext ? icachePkg::recover : icachePkg::run;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= icachePkg::idleReset;
            outstanding <= 1'b0;
            fetchAddr   <= `ICACHE_RESET_PC;
        end else begin
            state       <= nextState;
            outstanding <= outstandingNext;
            if (accept) begin
                fetchAddr <= pc;
            end
        end
    end

    assign pauseReq   = !accept;
    assign fillSet    = fetchAddr[`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS];
    assign lookupTag  = fetchAddr[`ICACHE_ADDR_BITS-1 -: `ICACHE_TAG_BITS];
    assign rdSet      = accept ? pc[`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS] : fillSet;
    assign memReqAddr = {fetchAddr[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS],
                         {`ICACHE_OFFSET_BITS{1'b0}}};

endmodule

`default_nettype wire

// File: logic/fetchOutput.sv
`default_nettype none

`include "icache_macros.svh"

module fetchOutput (
    input  wire icachePkg::addrT    fetchAddr,
    input  wire                     outValid,
    input  wire                     fromResp,
    input  wire icachePkg::lineT    respLine,
    input  wire icachePkg::wayMaskT hitWay,
    input  wire icachePkg::lineT    way0Line,
    input  wire icachePkg::lineT    way1Line,
    input  wire icachePkg::lineT    way2Line,
    input  wire icachePkg::lineT    way3Line,
    output icachePkg::instT         inst0,
    output icachePkg::addrT         inst0Pc,
    output logic                    inst0Valid,
    output icachePkg::instT         inst1,
    output icachePkg::addrT         inst1Pc,
    output logic                    inst1Valid
);

    icachePkg::lineT                line;
    logic [2*`ICACHE_INST_BITS-1:0] pair;

    // a refill forwards the memory line directly
    always_comb begin
        if (fromResp) begin
            line = respLine;
        end else if (hitWay[0]) begin
            line = way0Line;
        end else if (hitWay[1]) begin
            line = way1Line;
        end else if (hitWay[2]) begin
            line = way2Line;
        end else if (hitWay[3]) begin
            line = way3Line;
        end else begin
            line = '0;
        end
    end

    // offset bit 3 selects the upper half of the line
    assign pair  = fetchAddr[3] ? line[`ICACHE_LINE_BITS-1 -: 2*`ICACHE_INST_BITS]
                                : line[2*`ICACHE_INST_BITS-1:0];
    assign inst0 = pair[`ICACHE_INST_BITS-1:0];
    assign inst1 = pair[2*`ICACHE_INST_BITS-1 -: `ICACHE_INST_BITS];

    assign inst0Pc    = {fetchAddr[`ICACHE_ADDR_BITS-1:3], 3'b000};
    assign inst1Pc    = {fetchAddr[`ICACHE_ADDR_BITS-1:3], 3'b100};
    assign inst0Valid = outValid && !fetchAddr[2];
    assign inst1Valid = outValid;

endmodule

`default_nettype wire

// File: logic/icacheTop.sv
`default_nettype none

module icacheTop (
    input  wire                  clk,
    input  wire                  rst,
    input  wire icachePkg::addrT pc,
    input  wire                  flush,
    output logic                 pauseReq,
    output icachePkg::instT      inst0,
    output icachePkg::addrT      inst0Pc,
    output logic                 inst0Valid,
    output icachePkg::instT      inst1,
    output icachePkg::addrT      inst1Pc,
    output logic                 inst1Valid,
    output logic                 memReqValid,
    output icachePkg::addrT      memReqAddr,
    input  wire                  memReqReady,
    input  wire                  memRespValid,
    input  wire icachePkg::lineT memRespLine
);

    wire icachePkg::setT     rdSet;
    wire icachePkg::setT     fillSet;
    wire icachePkg::tagT     lookupTag;
    wire icachePkg::addrT    fetchAddr;
    wire                     fillEn;
    wire                     outValid;
    wire                     fromResp;
    wire                     hit;
    wire icachePkg::wayMaskT hitWay;
    wire icachePkg::wayMaskT wayFill;
    wire icachePkg::wayMaskT wayHit;
    wire icachePkg::wayMaskT wayValid;
    wire icachePkg::lineT    way0Line;
    wire icachePkg::lineT    way1Line;
    wire icachePkg::lineT    way2Line;
    wire icachePkg::lineT    way3Line;

    fetchCtrl ctrl (
        .clk, .rst, .pc, .flush, .hit,
        .memReqReady, .memRespValid, .pauseReq, .memReqValid, .memReqAddr,
        .rdSet, .lookupTag, .fetchAddr, .fillEn, .fillSet, .outValid, .fromResp
    );

    // the refill tag is the tag of the captured address
    cacheWay way0 (
        .clk, .rst, .rdSet, .lookupTag,
        .wrEn(wayFill[0]), .wrSet(fillSet), .wrTag(lookupTag), .wrLine(memRespLine),
        .hit(wayHit[0]), .lineValid(wayValid[0]), .rdLine(way0Line)
    );

    cacheWay way1 (
        .clk, .rst, .rdSet, .lookupTag,
        .wrEn(wayFill[1]), .wrSet(fillSet), .wrTag(lookupTag), .wrLine(memRespLine),
        .hit(wayHit[1]), .lineValid(wayValid[1]), .rdLine(way1Line)
    );

    cacheWay way2 (
        .clk, .rst, .rdSet, .lookupTag,
        .wrEn(wayFill[2]), .wrSet(fillSet), .wrTag(lookupTag), .wrLine(memRespLine),
        .hit(wayHit[2]), .lineValid(wayValid[2]), .rdLine(way2Line)
    );

    cacheWay way3 (
        .clk, .rst, .rdSet, .lookupTag,
        .wrEn(wayFill[3]), .wrSet(fillSet), .wrTag(lookupTag), .wrLine(memRespLine),
        .hit(wayHit[3]), .lineValid(wayValid[3]), .rdLine(way3Line)
    );

    waySelect select (
        .clk, .rst, .set(fillSet), .wayHit, .wayValid, .fillEn,
        .hit, .hitWay, .wayFill
    );

    fetchOutput out (
        .fetchAddr, .outValid, .fromResp, .respLine(memRespLine), .hitWay,
        .way0Line, .way1Line, .way2Line, .way3Line,
        .inst0, .inst0Pc, .inst0Valid, .inst1, .inst1Pc, .inst1Valid
    );

endmodule

`default_nettype wire

// File: dv/icache_props.sv
`default_nettype none

module icacheProps (
    input wire                  clk,
    input wire                  rst,
    input wire icachePkg::addrT pc,
    input wire                  flush,
    input wire                  pauseReq,
    input wire icachePkg::instT inst0,
    input wire icachePkg::addrT inst0Pc,
    input wire                  inst0Valid,
    input wire icachePkg::instT inst1,
    input wire icachePkg::addrT inst1Pc,
    input wire                  inst1Valid,
    input wire                  memReqValid,
    input wire icachePkg::addrT memReqAddr,
    input wire                  memReqReady
);
    timeunit 1ns;
    timeprecision 1ps;

    // memory model word at address A is A xor this pattern
    localparam icachePkg::instT linePattern = 32'h5A3C_96E1;

    int              failCount = 0;
    icachePkg::addrT lastPc;
    logic            owed;

    // address the cache took last, as the core sees it
    always_ff @(posedge clk) begin
        if (rst) begin
            lastPc <= '0;
        end else if (!pauseReq) begin
            lastPc <= pc;
        end
    end

    // an accepted address is owed a pair unless a flush drops it
    always_ff @(posedge clk) begin
        if (rst) begin
            owed <= 1'b0;
        end else if (flush || !pauseReq) begin
            owed <= !pauseReq;
        end
    end

    dataCheck: assert property (@(posedge clk) disable iff (rst)
        inst1Valid |-> inst1 == (inst1Pc ^ linePattern)
            && inst1Pc == {lastPc[31:3], 3'b100} && inst0Pc == {lastPc[31:3], 3'b000}
            && inst0Valid == !lastPc[2] && (!inst0Valid || inst0 == (inst0Pc ^ linePattern)))
        else begin
            $error("delivered pair does not match the memory model");
            failCount++;
        end

    deliver: assert property (@(posedge clk) disable iff (rst)
        owed && !pauseReq && !flush |-> inst1Valid)
        else begin
            $error("accepted address was not delivered when the stall dropped");
            failCount++;
        end

    reqStable: assert property (@(posedge clk) disable iff (rst)
        memReqValid && !memReqReady && !flush |=> memReqValid && $stable(memReqAddr))
        else begin
            $error("line request changed before it was accepted");
            failCount++;
        end

    reqAddr: assert property (@(posedge clk) disable iff (rst)
        memReqValid |-> memReqAddr == {lastPc[31:4], 4'h0})
        else begin
            $error("line request address is not the aligned fetch address");
            failCount++;
        end

    stallQuiet: assert property (@(posedge clk) disable iff (rst)
        pauseReq |-> !inst0Valid && !inst1Valid)
        else begin
            $error("instruction valid while stalled");
            failCount++;
        end

    resetQuiet: assert property (@(posedge clk)
        rst |=> !pauseReq && !memReqValid && !inst0Valid && !inst1Valid)
        else begin
            $error("outputs not quiet after reset");
            failCount++;
        end

endmodule

bind icacheTop icacheProps props (
    .clk, .rst, .pc, .flush, .pauseReq, .inst0, .inst0Pc, .inst0Valid,
    .inst1, .inst1Pc, .inst1Valid, .memReqValid, .memReqAddr, .memReqReady
);

`default_nettype wire

// File: dv/icacheTb.sv
`default_nettype none

module icacheTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam icachePkg::instT linePattern = 32'h5A3C_96E1;
    localparam int maxRespDelay = 8;
    localparam int fetchBudget = 64;
    localparam int cycleNs = 100;

    logic            clk = 1'b0;
    logic            rst = 1'b1;
    icachePkg::addrT pc = '0;
    logic            flush = 1'b0;
    logic            pauseReq;
    icachePkg::instT inst0;
    icachePkg::addrT inst0Pc;
    logic            inst0Valid;
    icachePkg::instT inst1;
    icachePkg::addrT inst1Pc;
    logic            inst1Valid;
    logic            memReqValid;
    icachePkg::addrT memReqAddr;
    logic            memReqReady = 1'b0;
    logic            memRespValid = 1'b0;
    icachePkg::lineT memRespLine = '0;

    logic [31:0]     memRng = 32'd91576;
    logic [31:0]     stimRng = 32'd91576;
    logic            backPressure = 1'b0;
    logic            slowResp = 1'b0;
    logic            pending = 1'b0;
    icachePkg::addrT pendAddr = '0;
    int              respDelay = 0;
    int              reqCount = 0;
    int              tbErrors = 0;
    int              testCount = 0;

    icacheTop DUT (
        .clk, .rst, .pc, .flush, .pauseReq, .inst0, .inst0Pc, .inst0Valid,
        .inst1, .inst1Pc, .inst1Valid, .memReqValid, .memReqAddr,
        .memReqReady, .memRespValid, .memRespLine
    );

    always #(cycleNs / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic icachePkg::lineT lineFor(input icachePkg::addrT base);
        icachePkg::lineT line;
        for (int k = 0; k < 4; k++) begin
            line[32*k +: 32] = (base + 32'(4 * k)) ^ linePattern;
        end
        return line;
    endfunction

    // memory with random ready and one line in flight
    always @(posedge clk) begin
        if (rst) begin
            memReqReady  <= 1'b0;
            memRespValid <= 1'b0;
            pending      <= 1'b0;
        end else begin
            memRng = xorshift(memRng);
            memRespValid <= 1'b0;
            if (pending) begin
                if (respDelay == 0) begin
                    memRespValid <= 1'b1;
                    memRespLine  <= lineFor(pendAddr);
                    pending      <= 1'b0;
                end else begin
                    respDelay <= respDelay - 1;
                end
            end else if (memReqValid && memReqReady) begin
                pending   <= 1'b1;
                pendAddr  <= memReqAddr;
                respDelay <= slowResp ? maxRespDelay : int'(memRng[2:0]);
                reqCount  <= reqCount + 1;
            end
            memReqReady <= backPressure ? (memRng[9:8] != 2'b00) : 1'b1;
        end
    end

    task automatic fetch(input icachePkg::addrT addr);
        pc <= addr;
        @(posedge clk);
        while (pauseReq) @(posedge clk);
    endtask

    task automatic drain();
        repeat (2) @(posedge clk);
        while (pauseReq) @(posedge clk);
    endtask

    task automatic checkReqs(input string what, input int expected, input int got);
        if (expected != got) begin
            $display("[ERROR] %s reqCount delta: expected %h, got %h", what, expected, got);
            tbErrors++;
        end
    endtask

    task automatic report(input string name);
        testCount++;
        $display("test %0d %s finished, errors so far %0d", testCount, name,
                 tbErrors + DUT.props.failCount);
    endtask

    initial begin
        int base;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        drain();
        report("reset");

        base = reqCount;
        fetch(32'h0001_1A2C);
        drain();
        checkReqs("cold miss", 1, reqCount - base);
        report("cold miss");

        base = reqCount;
        fetch(32'h0001_1A20);
        drain();
        checkReqs("line hit", 0, reqCount - base);
        report("line hit");

        // four tags in set 5, then a fifth; revisit in reverse so the refill lands on a seen way
        for (int i = 0; i < 4; i++) fetch(((32'h100 + i) << 10) | 32'h58);
        drain();
        base = reqCount;
        for (int i = 0; i < 4; i++) fetch(((32'h100 + i) << 10) | 32'h58);
        drain();
        checkReqs("four way revisit", 0, reqCount - base);
        fetch(32'h104 << 10 | 32'h58);
        drain();
        base = reqCount;
        for (int i = 3; i >= 0; i--) fetch(((32'h100 + i) << 10) | 32'h58);
        drain();
        checkReqs("eviction", 1, reqCount - base);
        report("eviction");

        slowResp <= 1'b1;
        base = reqCount;
        pc <= 32'h0002_3390;
        @(posedge clk);
        while (!(memReqValid && memReqReady)) @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        while (!memRespValid) @(posedge clk);
        drain();
        slowResp <= 1'b0;
        checkReqs("flush recovery", 2, reqCount - base);
        report("flush recovery");

        backPressure <= 1'b1;
        repeat (40) begin
            stimRng = xorshift(stimRng);
            fetch(stimRng & 32'h0000_3FFC);
        end
        drain();
        backPressure <= 1'b0;
        report("random");

        $display("tests run %0d, errors %0d", testCount, tbErrors + DUT.props.failCount);
        if (tbErrors + DUT.props.failCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // fetch count times the slowest refill with ready waits
    initial begin
        #(fetchBudget * (maxRespDelay + 16) * cycleNs);
        $display("watchdog expired, the tests did not complete in time");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+logic
logic/icachePkg.sv
logic/cacheWay.sv
logic/waySelect.sv
logic/fetchCtrl.sv
logic/fetchOutput.sv
logic/icacheTop.sv
dv/icache_props.sv
dv/icacheTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= icacheTb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --assert
PASS_TEXT ?= NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST) | grep -v '^+') logic/icache_macros.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
